// File: all.f
hw/iqe_pkg.sv
hw/iqe_step_if.sv
hw/iqe_ram_if.sv
hw/iqe_ram.sv
hw/iqe_lane_align.sv
hw/iqe_occupancy.sv
hw/iqe_ptr_ctrl.sv
hw/iqe_top.sv
sim/iqe_assertions.sv
sim/iqe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and decides pass or fail from sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module iqe_tb -Mdir obj_dir -f all.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Viqe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/iqe_tb.sv
/* Directed testbench for the side-data buffer with a queue model per thread.
   Tests never pop more than the model holds, and rd_stall is only held over full slots. */
`timescale 1ns/100ps
`default_nettype none

module iqe_tb import iqe_pkg::*; ();

  localparam int STALL_LEVEL = 13;

  logic       clk = 1'b0;
  logic       rst;
  logic       flush;
  thread_t    flush_thread;
  logic       fetch_stall;
  logic       full;
  logic       wr_en;
  thread_t    wr_thread;
  wr_cnt_t    wr_count;
  lane_t      wr_start;
  iqe_extra_t wr_data0;
  iqe_extra_t wr_data1;
  iqe_extra_t wr_data2;
  iqe_extra_t wr_data3;
  logic       rd_stall;
  thread_t    rd_thread;
  rd_cnt_t    rd_count;
  iqe_extra_t rd_data0;
  iqe_extra_t rd_data1;

  iqe_extra_t mq [NUM_THREADS][$];  // Reference contents, oldest first.
  iqe_extra_t exp0;
  iqe_extra_t exp1;
  int         exp_n = 0;            // Valid entries expected on the read ports.
  int         checks = 0;
  int         errors = 0;

  iqe_top #(
    .STALL_LEVEL(STALL_LEVEL)
  ) uut (.*);

  always #10 clk = ~clk;

  task automatic check_extra(input iqe_extra_t got, input iqe_extra_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // One clock cycle of stimulus, followed by the model update for that cycle.
  task automatic do_cycle(input logic we, input thread_t wt, input wr_cnt_t wc, input lane_t ws,
                          input thread_t rt, input rd_cnt_t rc, input logic rs,
                          input logic fs, input logic fl, input thread_t ft);
    iqe_extra_t lane_val [WR_LANES];
    logic       accepted;
    int         src;
    @(posedge clk);
    for (int i = 0; i < WR_LANES; i++) begin
      lane_val[i] = iqe_extra_t'($urandom);
    end
    wr_en        <= we;
    wr_thread    <= wt;
    wr_count     <= wc;
    wr_start     <= ws;
    wr_data0     <= lane_val[0];
    wr_data1     <= lane_val[1];
    wr_data2     <= lane_val[2];
    wr_data3     <= lane_val[3];
    rd_thread    <= rt;
    rd_count     <= rc;
    rd_stall     <= rs;
    fetch_stall  <= fs;
    flush        <= fl;
    flush_thread <= ft;
    @(negedge clk);
    if (exp_n > 0) check_extra(rd_data0, exp0, "rd_data0");
    if (exp_n > 1) check_extra(rd_data1, exp1, "rd_data1");
    check_flag(full, mq[wt].size() >= STALL_LEVEL, "full");
    accepted = we && !fs && (mq[wt].size() < STALL_LEVEL);
    if (fl) mq[ft].delete();
    if (accepted && !(fl && ft == wt)) begin
      for (int i = 0; i < int'(wc); i++) begin
        src = (int'(ws) + i > WR_LANES - 1) ? WR_LANES - 1 : int'(ws) + i;  // Clamp to lane 3.
        mq[wt].push_back(lane_val[src]);
      end
    end
    if (!rs && !(fl && ft == rt)) begin
      for (int i = 0; i < int'(rc); i++) begin
        if (mq[rt].size() > 0) void'(mq[rt].pop_front());
      end
    end
    if (!rs) begin  // A stalled cycle keeps the previous read data.
      exp_n = mq[rt].size();
      if (exp_n > 0) exp0 = mq[rt][0];
      if (exp_n > 1) exp1 = mq[rt][1];
    end
  endtask

  task automatic push(input thread_t t, input wr_cnt_t n, input lane_t start);
    do_cycle(1'b1, t, n, start, t, 2'd0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic pop(input thread_t t, input rd_cnt_t n);
    do_cycle(1'b0, t, 3'd0, 2'd0, t, n, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic drain(input thread_t t);
    int guard;
    guard = 0;
    while (mq[t].size() > 0 && guard < 20) begin
      pop(t, (mq[t].size() > 1) ? 2'd2 : 2'd1);
      guard++;
    end
    if (mq[t].size() > 0) begin
      $display("Timeout: thread %0d did not drain within 20 cycles", t);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  task automatic test_basic_order();
    int err0;
    err0 = errors;
    push(1'b0, 3'd4, 2'd0);
    pop(1'b0, 2'd2);
    do_cycle(1'b1, 1'b0, 3'd2, 2'd0, 1'b0, 2'd2, 1'b0, 1'b0, 1'b0, 1'b0);  // Push and pop together.
    drain(1'b0);
    report_test("basic_order", err0);
  endtask

  task automatic test_lane_align();
    int err0;
    err0 = errors;
    for (int s = 1; s < WR_LANES; s++) begin
      for (int n = 1; n <= WR_LANES; n++) begin
        push(1'b0, wr_cnt_t'(n), lane_t'(s));
        drain(1'b0);
      end
    end
    report_test("lane_align", err0);
  endtask

  task automatic test_full();
    int err0;
    int guard;
    err0 = errors;
    guard = 0;
    while (!full && guard < 30) begin
      push(1'b1, 3'd1, 2'd0);
      guard++;
    end
    if (!full) begin
      $display("Timeout: full never rose on thread 1");
      errors++;
    end
    push(1'b1, 3'd4, 2'd0);  // Refused while full.
    pop(1'b1, 2'd2);
    pop(1'b1, 2'd0);
    do_cycle(1'b1, 1'b1, 3'd4, 2'd0, 1'b1, 2'd0, 1'b0, 1'b1, 1'b0, 1'b0);
    drain(1'b1);
    push(1'b1, 3'd1, 2'd0);
    drain(1'b1);
    report_test("full_backpressure", err0);
  endtask

  task automatic test_threads();
    int err0;
    err0 = errors;
    for (int i = 0; i < 12; i++) begin
      push(1'b0, 3'd3, 2'd0);
      pop(1'b0, 2'd2);
      push(1'b1, 3'd2, 2'd1);
      pop(1'b1, 2'd1);
    end
    drain(1'b0);
    drain(1'b1);
    report_test("thread_independence", err0);
  endtask

  task automatic test_flush();
    int err0;
    err0 = errors;
    repeat (3) push(1'b1, 3'd4, 2'd0);
    repeat (2) push(1'b0, 3'd4, 2'd0);
    do_cycle(1'b1, 1'b1, 3'd1, 2'd0, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1, 1'b0);
    push(1'b0, 3'd2, 2'd0);
    drain(1'b0);
    push(1'b1, 3'd4, 2'd0);  // Thread 1 is still full.
    drain(1'b1);
    report_test("flush", err0);
  endtask

  task automatic test_read_stall();
    int err0;
    err0 = errors;
    push(1'b0, 3'd4, 2'd0);
    for (int i = 0; i < 4; i++) begin  // Read thread moves to 1 halfway through the stall.
      do_cycle(1'b1, 1'b0, 3'd2, 2'd1, thread_t'(i / 2), 2'd2, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    drain(1'b0);
    report_test("read_stall", err0);
  endtask

  initial begin
    void'($urandom(68982));
    rst          <= 1'b1;
    flush        <= 1'b0;
    flush_thread <= 1'b0;
    fetch_stall  <= 1'b0;
    wr_en        <= 1'b0;
    wr_thread    <= 1'b0;
    wr_count     <= 3'd0;
    wr_start     <= 2'd0;
    wr_data0     <= '0;
    wr_data1     <= '0;
    wr_data2     <= '0;
    wr_data3     <= '0;
    rd_stall     <= 1'b0;
    rd_thread    <= 1'b0;
    rd_count     <= 2'd0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_basic_order();
    test_lane_align();
    test_full();
    test_threads();
    test_flush();
    test_read_stall();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/iqe_assertions.sv
/* Bound to iqe_top. The read-hold check assumes the held slots are not rewritten. */
`timescale 1ns/100ps
`default_nettype none

module iqe_assertions import iqe_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       full,
  input logic       rd_stall,
  input iqe_extra_t rd_data0,
  input iqe_extra_t rd_data1,
  input wr_cnt_t    wr_count,
  input rd_cnt_t    rd_count
);

  full_after_reset: assert property (@(posedge clk) $fell(rst) |-> !full)
    else $error("full is high in the cycle after reset");

  // Registered read addresses hold across a stalled cycle.
  read_hold: assert property (@(posedge clk) disable iff (rst)
    rd_stall |=> ($stable(rd_data0) && $stable(rd_data1)))
    else $error("read data changed after a stalled cycle");

  count_range: assert property (@(posedge clk) disable iff (rst)
    (wr_count <= 3'd4) && (rd_count <= 2'd2))
    else $error("push or pop count out of range");

endmodule

bind iqe_top iqe_assertions u_assertions (.*);

`default_nettype wire

// File: hw/iqe_top.sv
/* Side-data buffer of the instruction queue for two threads.
   Read data lags the unstalled cycle by one edge; full refuses pushes. */
`timescale 1ns/100ps
`default_nettype none

module iqe_top import iqe_pkg::*; #(
  parameter int unsigned STALL_LEVEL = 13
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  thread_t    flush_thread,
  input  logic       fetch_stall,
  output logic       full,
  input  logic       wr_en,
  input  thread_t    wr_thread,
  input  wr_cnt_t    wr_count,
  input  lane_t      wr_start,
  input  iqe_extra_t wr_data0,
  input  iqe_extra_t wr_data1,
  input  iqe_extra_t wr_data2,
  input  iqe_extra_t wr_data3,
  input  logic       rd_stall,
  input  thread_t    rd_thread,
  input  rd_cnt_t    rd_count,
  output iqe_extra_t rd_data0,
  output iqe_extra_t rd_data1
);

  iqe_extra_t lanes     [WR_LANES];
  iqe_extra_t port_data [WR_LANES];
  iqe_extra_t rd_data   [RD_PORTS];

  iqe_step_if step ();
  iqe_ram_if  ram_bus ();

  assign lanes[0] = wr_data0;
  assign lanes[1] = wr_data1;
  assign lanes[2] = wr_data2;
  assign lanes[3] = wr_data3;
  assign rd_data0 = rd_data[0];
  assign rd_data1 = rd_data[1];

  iqe_occupancy #(
    .STALL_LEVEL(STALL_LEVEL)
  ) u_occupancy (
    .clk(clk),
    .rst(rst),
    .wr_en(wr_en),
    .fetch_stall(fetch_stall),
    .wr_thread(wr_thread),
    .wr_count(wr_count),
    .rd_stall(rd_stall),
    .rd_thread(rd_thread),
    .rd_count(rd_count),
    .flush(flush),
    .flush_thread(flush_thread),
    .full(full),
    .step(step.ctrl)
  );

  iqe_ptr_ctrl u_ptr_ctrl (
    .clk(clk),
    .rst(rst),
    .step(step.follow),
    .ram(ram_bus.drive)
  );

  iqe_lane_align #(
    .payload_t(iqe_extra_t)
  ) u_lane_align (
    .wr_start(wr_start),
    .lanes(lanes),
    .port_data(port_data)
  );

  iqe_ram #(
    .payload_t(iqe_extra_t)
  ) u_ram (
    .clk(clk),
    .rst(rst),
    .ram(ram_bus.mem),
    .wr_data(port_data),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: hw/iqe_ptr_ctrl.sv
/* Head and tail per thread wrap modulo 16 inside the thread's half of the RAM.
   Read addresses use the head after this cycle's pop and flush. */
`timescale 1ns/100ps
`default_nettype none

module iqe_ptr_ctrl import iqe_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  iqe_step_if.follow step,
  iqe_ram_if.drive   ram
);

  ptr_t head     [NUM_THREADS];
  ptr_t tail     [NUM_THREADS];
  ptr_t head_nxt [NUM_THREADS];
  ptr_t tail_nxt [NUM_THREADS];

  always_comb begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      head_nxt[t] = head[t];
      tail_nxt[t] = tail[t];
      if (step.flush && step.flush_thread == thread_t'(t)) begin
        head_nxt[t] = '0;
        tail_nxt[t] = '0;
      end else begin
        if (step.wr_go && step.wr_thread == thread_t'(t)) begin
          tail_nxt[t] = tail[t] + ptr_t'(step.wr_count);
        end
        if (step.rd_go && step.rd_thread == thread_t'(t)) begin
          head_nxt[t] = head[t] + ptr_t'(step.rd_count);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (rst) begin
        head[t] <= '0;
        tail[t] <= '0;
      end else begin
        head[t] <= head_nxt[t];
        tail[t] <= tail_nxt[t];
      end
    end
  end

  for (genvar k = 0; k < WR_LANES; k++) begin : g_wr
    assign ram.wr_addr[k] = {step.wr_thread, ptr_t'(tail[step.wr_thread] + ptr_t'(k))};
    assign ram.wr_en[k]   = step.wr_go && (wr_cnt_t'(k) < step.wr_count);
  end

  for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
    assign ram.rd_addr[p] = {step.rd_thread, ptr_t'(head_nxt[step.rd_thread] + ptr_t'(p))};
  end

  assign ram.rd_en = step.rd_go;

endmodule

`default_nettype wire

// File: hw/iqe_occupancy.sv
/* No underflow check: decode must never pop more than was pushed.
   full looks at the write thread only. */
`timescale 1ns/100ps
`default_nettype none

module iqe_occupancy import iqe_pkg::*; #(
  parameter int unsigned STALL_LEVEL = 13
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    wr_en,
  input  logic    fetch_stall,
  input  thread_t wr_thread,
  input  wr_cnt_t wr_count,
  input  logic    rd_stall,
  input  thread_t rd_thread,
  input  rd_cnt_t rd_count,
  input  logic    flush,
  input  thread_t flush_thread,
  output logic    full,
  iqe_step_if.ctrl step
);

  occ_t count     [NUM_THREADS];
  occ_t count_nxt [NUM_THREADS];
  logic wr_go;
  logic rd_go;

  assign full  = (count[wr_thread] >= occ_t'(STALL_LEVEL));
  assign wr_go = wr_en && !fetch_stall && !full;  // Refused pushes are simply dropped.
  assign rd_go = !rd_stall;

  assign step.wr_go        = wr_go;
  assign step.wr_thread    = wr_thread;
  assign step.wr_count     = wr_count;
  assign step.rd_go        = rd_go;
  assign step.rd_thread    = rd_thread;
  assign step.rd_count     = rd_count;
  assign step.flush        = flush;
  assign step.flush_thread = flush_thread;

  always_comb begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      count_nxt[t] = count[t];
      if (flush && flush_thread == thread_t'(t)) begin
        count_nxt[t] = '0;  // Same-cycle push or pop on this thread is lost.
      end else begin
        if (wr_go && wr_thread == thread_t'(t)) begin
          count_nxt[t] = count_nxt[t] + occ_t'(wr_count);
        end
        if (rd_go && rd_thread == thread_t'(t)) begin
          count_nxt[t] = count_nxt[t] - occ_t'(rd_count);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (rst) begin
        count[t] <= '0;
      end else begin
        count[t] <= count_nxt[t];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/iqe_lane_align.sv
/* Packs a push that starts mid-bundle onto consecutive write ports.
   Ports past the last lane repeat lane 3. */
`timescale 1ns/100ps
`default_nettype none

module iqe_lane_align import iqe_pkg::*; #(
  parameter type payload_t = iqe_extra_t
) (
  input  lane_t    wr_start,
  input  payload_t lanes [WR_LANES],
  output payload_t port_data [WR_LANES]
);

  for (genvar k = 0; k < WR_LANES; k++) begin : g_port
    logic [$bits(lane_t):0] idx;  // One extra bit to see the overrun.

    assign idx = {1'b0, wr_start} + ($bits(lane_t) + 1)'(k);
    assign port_data[k] = (idx > ($bits(lane_t) + 1)'(WR_LANES - 1)) ?
                          lanes[WR_LANES-1] : lanes[idx[$bits(lane_t)-1:0]];
  end

endmodule

`default_nettype wire

// File: hw/iqe_ram.sv
/* Write ports must not hit the same slot in one cycle.
   Read data follows the registered address, so same-edge writes show through. */
`timescale 1ns/100ps
`default_nettype none

module iqe_ram import iqe_pkg::*; #(
  parameter type payload_t = iqe_extra_t
) (
  input  logic      clk,
  input  logic      rst,
  iqe_ram_if.mem    ram,
  input  payload_t  wr_data [WR_LANES],
  output payload_t  rd_data [RD_PORTS]
);

  localparam int ENTRIES = NUM_THREADS * DEPTH;

  payload_t mem [ENTRIES];
  slot_t    rd_addr_q [RD_PORTS];

  always_ff @(posedge clk) begin
    for (int k = 0; k < WR_LANES; k++) begin
      if (ram.wr_en[k]) begin
        mem[ram.wr_addr[k]] <= wr_data[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < RD_PORTS; p++) begin
      if (rst) begin
        rd_addr_q[p] <= '0;
      end else if (ram.rd_en) begin
        rd_addr_q[p] <= ram.rd_addr[p];  // Held while decode stalls.
      end
    end
  end

  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      rd_data[p] = mem[rd_addr_q[p]];
    end
  end

endmodule

`default_nettype wire

// File: hw/iqe_ram_if.sv
/* Addresses and enables for the shared side-data RAM. */
`timescale 1ns/100ps
`default_nettype none

interface iqe_ram_if import iqe_pkg::*; ();

  logic                rd_en;
  slot_t               rd_addr [RD_PORTS];
  logic [WR_LANES-1:0] wr_en;
  slot_t               wr_addr [WR_LANES];

  modport drive (
    output rd_en, rd_addr, wr_en, wr_addr
  );

  modport mem (
    input rd_en, rd_addr, wr_en, wr_addr
  );

endinterface

`default_nettype wire

// File: hw/iqe_step_if.sv
/* Accepted push, pop and flush events, combinational within the cycle. */
`timescale 1ns/100ps
`default_nettype none

interface iqe_step_if import iqe_pkg::*; ();

  logic    wr_go;
  thread_t wr_thread;
  wr_cnt_t wr_count;
  logic    rd_go;         // High in every cycle without a read stall.
  thread_t rd_thread;
  rd_cnt_t rd_count;
  logic    flush;
  thread_t flush_thread;

  modport ctrl (
    output wr_go, wr_thread, wr_count, rd_go, rd_thread, rd_count, flush, flush_thread
  );

  modport follow (
    input wr_go, wr_thread, wr_count, rd_go, rd_thread, rd_count, flush, flush_thread
  );

endinterface

`default_nettype wire

// File: hw/iqe_pkg.sv
/* Sizes and types of the instruction queue side-data buffer.
   Two threads share one RAM with a fixed 16-slot half each. */
`default_nettype none

package iqe_pkg;

  localparam int NUM_THREADS = 2;
  localparam int DEPTH       = 16;
  localparam int WR_LANES    = 4;
  localparam int RD_PORTS    = 2;

  typedef logic [$clog2(NUM_THREADS)-1:0] thread_t;
  typedef logic [$clog2(DEPTH)-1:0]       ptr_t;
  typedef logic [$bits(thread_t)+$bits(ptr_t)-1:0] slot_t;  // Thread in the upper bit.
  typedef logic [$clog2(DEPTH+1)-1:0]     occ_t;
  typedef logic [$clog2(WR_LANES+1)-1:0]  wr_cnt_t;
  typedef logic [$clog2(RD_PORTS+1)-1:0]  rd_cnt_t;
  typedef logic [$clog2(WR_LANES)-1:0]    lane_t;

  typedef struct packed {
    logic [11:0] pc_offset;
    logic [4:0]  imm_hint;
    logic [2:0]  flags;
  } iqe_extra_t;

endpackage

`default_nettype wire
